// ==== Bender.yml ====
package:
  name: fetch

export_include_dirs:
  - hw

sources:
  - files:
      - hw/fetch_pkg.sv
      - hw/pc_gen.sv
      - hw/ifetch.sv
      - hw/imem.sv
      - hw/fetch_top.sv
  - target: test
    files:
      - tb/fetch_assert.sv
      - tb/tb_fetch_top.sv

// ==== hw/fetch_pkg.sv ====
`include "fetch_settings.svh"

package fetch_pkg;

    // one instruction or data word
    typedef logic [`FETCH_XLEN-1:0] word_t;

    // byte address, fetches are word aligned
    typedef logic [`FETCH_XLEN-1:0] addr_t;

    // fetch controller states
    typedef enum logic [1:0] {
        s_idle         = 2'b00, // nothing outstanding
        s_wait_gnt     = 2'b01, // request on the bus, not yet granted
        s_wait_rvalid  = 2'b10, // granted, response still to come
        s_abort_rvalid = 2'b11  // granted before a redirect, response is dropped
    } fetch_state_e;

endpackage

// ==== hw/fetch_settings.svh ====
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// datapath width of instructions and addresses
`define FETCH_XLEN 32

// addi x0, x0, 0 shown to decode when no instruction is ready
`define FETCH_NOP 32'h0000_0013

`define FETCH_RESET_PC 32'h0000_0000

`define IMEM_DEPTH 256   // words, addresses wrap at this size
`define IMEM_LATENCY 2   // grant to rvalid, 1 to 4 supported

`endif

// ==== hw/fetch_top.sv ====
module fetch_top
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  reset,

    // program load
    input  logic  load_we_i,
    input  addr_t load_addr_i,
    input  word_t load_data_i,

    // pipeline control
    input  logic  stall_i,
    input  logic  redirect_i,
    input  addr_t redirect_pc_i,

    // to decode
    output word_t instr_o,
    output addr_t instr_pc_o,
    output logic  instr_valid_o
);

    addr_t pc;
    logic  pc_hold;

    logic  mem_req;
    addr_t mem_addr;
    logic  mem_gnt;
    logic  mem_rvalid;
    word_t mem_rdata;

    pc_gen i_pc_gen (
        .clk           (clk),
        .reset         (reset),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .hold_i        (pc_hold),
        .pc_o          (pc)
    );

    ifetch i_ifetch (
        .clk           (clk),
        .reset         (reset),
        .pc_i          (pc),
        .pc_hold_o     (pc_hold),
        .stall_i       (stall_i),
        .redirect_i    (redirect_i),
        .mem_req_o     (mem_req),
        .mem_addr_o    (mem_addr),
        .mem_gnt_i     (mem_gnt),
        .mem_rvalid_i  (mem_rvalid),
        .mem_rdata_i   (mem_rdata),
        .instr_o       (instr_o),
        .instr_pc_o    (instr_pc_o),
        .instr_valid_o (instr_valid_o)
    );

    imem i_imem (
        .clk         (clk),
        .reset       (reset),
        .load_we_i   (load_we_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i),
        .req_i       (mem_req),
        .addr_i      (mem_addr),
        .gnt_o       (mem_gnt),
        .rvalid_o    (mem_rvalid),
        .rdata_o     (mem_rdata)
    );

endmodule

// ==== hw/ifetch.sv ====
`include "fetch_settings.svh"

module ifetch
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  reset,

    // program counter side
    input  addr_t pc_i,
    output logic  pc_hold_o,

    // pipeline control
    input  logic  stall_i,       // decode cannot take instr_o
    input  logic  redirect_i,    // flush, new pc arrives next cycle

    // instruction memory, req/gnt/rvalid
    output logic  mem_req_o,
    output addr_t mem_addr_o,
    input  logic  mem_gnt_i,
    input  logic  mem_rvalid_i,
    input  word_t mem_rdata_i,

    // to decode
    output word_t instr_o,
    output addr_t instr_pc_o,
    output logic  instr_valid_o
);

    fetch_state_e state_q;
    fetch_state_e state_d;

    addr_t req_addr_q;        // pc of the request on the bus or in flight

    logic  backup_valid_q;
    word_t backup_instr_q;

    logic  resp_ok;           // response that belongs to the current stream
    logic  slot_busy;         // output will still hold an instruction next cycle
    logic  bus_free;          // no fetch outstanding after this cycle
    logic  issue;             // launch a request for pc_i

    assign resp_ok = (state_q == s_wait_rvalid) && mem_rvalid_i;

    // only one word can wait in the backup register, so no new fetch
    // while the output is stalled with something on it
    assign slot_busy = stall_i && (backup_valid_q || resp_ok);

    assign bus_free = (state_q == s_idle) ||
                      ((state_q inside {s_wait_rvalid, s_abort_rvalid}) && mem_rvalid_i);

    assign issue = bus_free && !redirect_i && !slot_busy;

    assign pc_hold_o = !issue; // pc_gen steps only when its address is taken

    always_comb begin
        state_d = state_q;
        case (state_q)
            s_idle: begin
                if (issue) begin
                    state_d = s_wait_gnt;
                end
            end
            s_wait_gnt: begin
                if (redirect_i) begin
                    state_d = s_idle;        // request withdrawn, never granted
                end else if (mem_gnt_i) begin
                    state_d = s_wait_rvalid;
                end
            end
            s_wait_rvalid, s_abort_rvalid: begin
                if (mem_rvalid_i) begin
                    state_d = issue ? s_wait_gnt : s_idle;
                end else if (redirect_i) begin
                    state_d = s_abort_rvalid; // late response must be thrown away
                end
            end
            default: begin
                state_d = s_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= s_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // address is captured once and stays put until granted
    always_ff @(posedge clk) begin
        if (issue) begin
            req_addr_q <= pc_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            backup_valid_q <= 1'b0;
        end else if (redirect_i) begin
            backup_valid_q <= 1'b0;   // flushed, not consumed
        end else if (stall_i && resp_ok) begin
            backup_valid_q <= 1'b1;
        end else if (!stall_i) begin
            backup_valid_q <= 1'b0;   // held word consumed this cycle
        end
    end

    always_ff @(posedge clk) begin
        if (stall_i && resp_ok && !backup_valid_q) begin
            backup_instr_q <= mem_rdata_i;
        end
    end

    // request is dropped from the bus the moment a redirect shows up
    assign mem_req_o  = (state_q == s_wait_gnt) && !redirect_i;
    assign mem_addr_o = req_addr_q;

    // a fresh response goes straight through, a stalled one is replayed
    // from the backup register until decode takes it
    assign instr_valid_o = backup_valid_q || resp_ok;
    assign instr_pc_o    = req_addr_q; // no issue while a word is held, so it still names it

    always_comb begin
        if (backup_valid_q) begin
            instr_o = backup_instr_q;
        end else if (resp_ok) begin
            instr_o = mem_rdata_i;
        end else begin
            instr_o = `FETCH_NOP;    // bubble
        end
    end

endmodule

// ==== hw/imem.sv ====
`include "fetch_settings.svh"

module imem
    import fetch_pkg::*;
#(
    parameter int LATENCY = `IMEM_LATENCY
) (
    input  logic  clk,
    input  logic  reset,

    // program load port, wins over fetches
    input  logic  load_we_i,
    input  addr_t load_addr_i,
    input  word_t load_data_i,

    // fetch port
    input  logic  req_i,
    input  addr_t addr_i,
    output logic  gnt_o,
    output logic  rvalid_o,
    output word_t rdata_o
);

    localparam int IDX_W = $clog2(`IMEM_DEPTH);

    word_t mem_q [`IMEM_DEPTH];

    logic [LATENCY-1:0] valid_q;     // response pipeline, stage 0 loaded at grant
    word_t              data_q [LATENCY];

    logic [IDX_W-1:0] load_idx;
    logic [IDX_W-1:0] fetch_idx;

    // byte address to word index, upper bits ignored so it wraps
    assign load_idx  = load_addr_i[IDX_W+1:2];
    assign fetch_idx = addr_i[IDX_W+1:2];

    assign gnt_o = req_i && !load_we_i; // no fetch in a cycle the array is written

    always_ff @(posedge clk) begin
        if (load_we_i) begin
            mem_q[load_idx] <= load_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= gnt_o;
            for (int i = 1; i < LATENCY; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // data rides along with the valid bits
    always_ff @(posedge clk) begin
        if (gnt_o) begin
            data_q[0] <= mem_q[fetch_idx];
        end
        for (int i = 1; i < LATENCY; i++) begin
            data_q[i] <= data_q[i-1];
        end
    end

    assign rvalid_o = valid_q[LATENCY-1];
    assign rdata_o  = data_q[LATENCY-1];

endmodule

// ==== hw/pc_gen.sv ====
`include "fetch_settings.svh"

module pc_gen
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  reset,

    input  logic  redirect_i,    // branch or jump from execute
    input  addr_t redirect_pc_i,
    input  logic  hold_i,        // fetch unit did not take pc_o this cycle

    output addr_t pc_o
);

    localparam addr_t PC_STEP = addr_t'(4);

    addr_t pc_q;
    addr_t pc_next;

    // redirect wins over hold, otherwise step one word per accepted address
    always_comb begin
        pc_next = pc_q;
        if (redirect_i) begin
            pc_next = redirect_pc_i;
        end else if (!hold_i) begin
            pc_next = pc_q + PC_STEP;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= `FETCH_RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q; // always the next address to fetch

endmodule

// ==== tb.f ====
+incdir+hw
hw/fetch_pkg.sv
hw/pc_gen.sv
hw/ifetch.sv
hw/imem.sv
hw/fetch_top.sv
tb/fetch_assert.sv
tb/tb_fetch_top.sv

// ==== tb/fetch_assert.sv ====
module fetch_assert
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  req_i,
    input  addr_t addr_i,
    input  logic  gnt_i,
    input  logic  rvalid_i,
    input  logic  redirect_i,
    input  logic  instr_valid_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned error_count = 0;   // read by the testbench at the end
    logic        outstanding_q;     // granted fetch waiting for rvalid

    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding_q <= 1'b0;
        end else if (req_i && gnt_i) begin
            outstanding_q <= 1'b1;
        end else if (rvalid_i) begin
            outstanding_q <= 1'b0;
        end
    end

    req_stable_a: assert property (@(posedge clk) disable iff (reset)
        req_i && !gnt_i |=> redirect_i || (req_i && $stable(addr_i)))
        else begin
            $error("request dropped or address changed before grant");
            error_count++;
        end

    single_outstanding_a: assert property (@(posedge clk) disable iff (reset)
        outstanding_q |-> !req_i)
        else begin
            $error("second request while a fetch is outstanding");
            error_count++;
        end

    redirect_flush_a: assert property (@(posedge clk) disable iff (reset)
        redirect_i |=> !instr_valid_i)
        else begin
            $error("instruction valid in the cycle after a redirect");
            error_count++;
        end

endmodule

bind ifetch fetch_assert i_fetch_assert (
    .clk           (clk),
    .reset         (reset),
    .req_i         (mem_req_o),
    .addr_i        (mem_addr_o),
    .gnt_i         (mem_gnt_i),
    .rvalid_i      (mem_rvalid_i),
    .redirect_i    (redirect_i),
    .instr_valid_i (instr_valid_o)
);

// ==== tb/tb_fetch_top.sv ====
`include "fetch_settings.svh"

module tb_fetch_top
    import fetch_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int IDX_W        = $clog2(`IMEM_DEPTH);
    localparam int SAFE_WORDS   = `IMEM_DEPTH * 3 / 8; // fetch window, well below the upper half
    localparam int PHASE_CYCLES = 500 + 600 + 600 + 600 + 4000;
    localparam int RUN_CYCLES   = RESET_CYCLES + `IMEM_DEPTH + PHASE_CYCLES;
    localparam int TIMEOUT_NS   = (RUN_CYCLES * 20 + 1000) * CLK_PERIOD;

    logic  clk;
    logic  reset;
    logic  load_we_i;
    addr_t load_addr_i;
    word_t load_data_i;
    logic  stall_i;
    logic  redirect_i;
    addr_t redirect_pc_i;
    word_t instr_o;
    addr_t instr_pc_o;
    logic  instr_valid_o;

    logic [31:0] lcg_state = 32'd67;
    word_t       mem_model [`IMEM_DEPTH];
    addr_t       exp_pc;            // pc of the next instruction decode should take
    int          consumed;
    logic        hold_pending;      // last cycle stalled with a valid instruction
    word_t       held_instr;
    addr_t       held_pc;

    fetch_top i_dut (
        .clk           (clk),
        .reset         (reset),
        .load_we_i     (load_we_i),
        .load_addr_i   (load_addr_i),
        .load_data_i   (load_data_i),
        .stall_i       (stall_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .instr_o       (instr_o),
        .instr_pc_o    (instr_pc_o),
        .instr_valid_o (instr_valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int unsigned rand_below(int unsigned n);
        logic [31:0] r;
        r = lcg_next();
        return int'(r[30:16]) % n; // low bits of an lcg are poor
    endfunction

    function automatic word_t random_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = lcg_next();
        lo = lcg_next();
        return {hi[23:8], lo[23:8]};
    endfunction

    task automatic fail_and_stop();
        $display("Result: FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error %s expected %h actual %h", name, expected, actual);
            fail_and_stop();
        end
    endtask

    // sampled just before the rising edge, once the inputs have settled
    task automatic check_outputs(input string name);
        if (hold_pending) begin
            check_equal({name, " stall valid"}, 32'd1, 32'(instr_valid_o));
            check_equal({name, " stall instr"}, held_instr, instr_o);
            check_equal({name, " stall pc"}, held_pc, instr_pc_o);
        end
        if (!instr_valid_o) begin
            check_equal({name, " bubble"}, `FETCH_NOP, instr_o);
        end
        if (redirect_i) begin
            exp_pc = redirect_pc_i; // output of this cycle is flushed
        end else if (instr_valid_o && !stall_i) begin
            check_equal({name, " pc"}, exp_pc, instr_pc_o);
            check_equal({name, " data"}, mem_model[exp_pc[IDX_W+1:2]], instr_o);
            exp_pc = exp_pc + 32'd4;
            consumed++;
        end
        hold_pending = instr_valid_o && stall_i && !redirect_i;
        held_instr   = instr_o;
        held_pc      = instr_pc_o;
    endtask

    task automatic drive_and_check(input string name, input int stall_pct,
                                   input int redirect_pct, input int write_pct);
        int unsigned widx;
        @(negedge clk);
        stall_i       = rand_below(100) < stall_pct;
        redirect_i    = rand_below(100) < redirect_pct;
        redirect_pc_i = addr_t'(rand_below(SAFE_WORDS) * 4);
        // with writes going on, pull the stream back before it nears the upper half
        if (write_pct > 0 && exp_pc[IDX_W+1:2] >= SAFE_WORDS) begin
            redirect_i = 1'b1;
        end
        widx        = `IMEM_DEPTH / 2 + rand_below(`IMEM_DEPTH / 2);
        load_we_i   = rand_below(100) < write_pct;
        load_addr_i = addr_t'(widx * 4);
        load_data_i = random_word();
        if (load_we_i) begin
            mem_model[widx] = load_data_i;
        end
        #(CLK_PERIOD / 2 - 1);
        check_outputs(name);
    endtask

    task automatic run_phase(input string name, input int cycles, input int stall_pct,
                             input int redirect_pct, input int write_pct);
        consumed = 0;
        repeat (cycles) drive_and_check(name, stall_pct, redirect_pct, write_pct);
        if (consumed == 0) begin
            $display("phase %s ended without a single consumed instruction", name);
            fail_and_stop();
        end
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("run timed out, the fetch unit stopped making progress");
        fail_and_stop();
    end

    initial begin
        reset         = 1'b1;
        load_we_i     = 1'b0;
        load_addr_i   = '0;
        load_data_i   = '0;
        stall_i       = 1'b0;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        exp_pc        = `FETCH_RESET_PC;
        hold_pending  = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        // back to back writes, the first fetch waits for its grant
        for (int i = 0; i < `IMEM_DEPTH; i++) begin
            @(negedge clk);
            load_we_i    = 1'b1;
            load_addr_i  = addr_t'(i * 4);
            load_data_i  = random_word();
            mem_model[i] = load_data_i;
        end

        run_phase("sequential", 500, 0, 0, 0);
        run_phase("stall", 600, 40, 0, 0);
        run_phase("redirect", 600, 0, 8, 0);
        run_phase("grant_conflict", 600, 0, 0, 40);
        run_phase("combined", 4000, 30, 5, 30);

        @(negedge clk);
        if (i_dut.i_ifetch.i_fetch_assert.error_count == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("protocol assertions failed during the run");
            fail_and_stop();
        end
    end

endmodule
